//--- common/uart_settings.svh
/*
  Line timing and line levels shared by the serial receivers and the testbench.
  Include this where a bit period or a line level is needed. The types are in uart_pkg.
*/

`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// system clock, 40 ns period
`define UART_CLK_FREQ 25_000_000

// baud rate, gives 16 clocks per bit
`define UART_BIT_FREQ 1_562_500

// line levels
`define UART_IDLE_BIT  1'b1  // line rests high
`define UART_START_BIT 1'b0  // start bit pulls low
`define UART_STOP_BIT  1'b1  // stop bit returns high

`endif

//--- common/uart_pkg.sv
/*
  Types for the dual line receive concentrator.
  A receiver reports an rx_char_t; the merger tags it with its line as a tagged_char_t.
*/

package uart_pkg;

  // line index, one bit for two lines
  typedef logic line_t;

  localparam line_t LINE_A = 1'b0;  // rx_a
  localparam line_t LINE_B = 1'b1;  // rx_b

  // one received character, 9 bits
  typedef struct packed {
    logic [7:0] data;  // lsb arrives first on the line
    logic       brk;   // low stop bit seen
  } rx_char_t;

  // character with its source line, 10 bits
  typedef struct packed {
    line_t    line;  // where it came from
    rx_char_t chr;   // what arrived
  } tagged_char_t;

endpackage

//--- serial_rx/serial_rx.sv
/*
  Asynchronous serial receiver, 8 data bits, 1 stop bit, no parity.
  Reports each frame as a one-cycle valid strobe with the character on chr.
  A low stop bit is reported with brk set, then the receiver waits half a bit.
*/

`timescale 1ns/1ps

`include "uart_settings.svh"

module serial_rx (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                rx,     // async line
  output logic                valid,  // one cycle per frame
  output uart_pkg::rx_char_t  chr     // held until the next frame
);

  // bit timing from the shared clock and baud settings
  localparam int unsigned BIT_PERIOD    = `UART_CLK_FREQ / `UART_BIT_FREQ;
  localparam int unsigned FULL_BIT_TIME = BIT_PERIOD - 1;
  localparam int unsigned HALF_BIT_TIME = (BIT_PERIOD >> 1) - 1;
  localparam int unsigned N_TIMER       = $clog2(BIT_PERIOD);

  // frame position, 0 start, 1..8 data, 9 stop
  localparam logic [3:0] BIT_START = 4'd0;
  localparam logic [3:0] BIT_STOP  = 4'd9;

  typedef enum logic [1:0] {
    ST_IDLE,     // waiting for a start edge
    ST_FRAME,    // sampling start, data and stop bits
    ST_HOLDOFF   // half bit pause after a break
  } state_t;

  state_t             state;
  logic [2:0]         sync;     // line synchronizer
  logic               rx_in;    // synchronized line
  logic [N_TIMER-1:0] timer;    // cycles until the next sample
  logic [3:0]         bit_cnt;  // position within the frame
  logic               sample;   // mid bit in a frame
  logic               stop_bad; // stop bit came in low

  assign rx_in    = sync[2];
  assign sample   = (state == ST_FRAME) && (timer == '0);
  assign stop_bad = (rx_in != `UART_STOP_BIT);

  // three flops, oldest sample in bit 2
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      sync <= {3{`UART_IDLE_BIT}};  // idle line after reset
    else
      sync <= {sync[1:0], rx};
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state   <= ST_IDLE;
      timer   <= '0;
      bit_cnt <= BIT_START;
      valid   <= 1'b0;
    end
    else
    begin
      valid <= 1'b0;  // strobe lasts one cycle
      if (timer != '0)
        timer <= timer - 1'b1;  // count down to mid bit
      case (state)
        ST_IDLE:
        begin
          if (rx_in == `UART_START_BIT)  // possible start edge
          begin
            timer   <= N_TIMER'(HALF_BIT_TIME);
            bit_cnt <= BIT_START;
            state   <= ST_FRAME;
          end
        end
        ST_FRAME:
        begin
          if (timer == '0)
          begin
            if (bit_cnt == BIT_START && rx_in != `UART_START_BIT)
              state <= ST_IDLE;  // glitch, no report
            else if (bit_cnt == BIT_STOP)
            begin
              valid <= 1'b1;  // frame done either way
              if (stop_bad)
              begin
                timer <= N_TIMER'(HALF_BIT_TIME);  // let the break settle
                state <= ST_HOLDOFF;
              end
              else
                state <= ST_IDLE;
            end
            else
            begin
              timer   <= N_TIMER'(FULL_BIT_TIME);  // next bit center
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        ST_HOLDOFF:
        begin
          if (timer == '0)
            state <= ST_IDLE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // character payload, lsb first into the top
  always_ff @(posedge clk)
  begin
    if (sample && bit_cnt != BIT_START && bit_cnt != BIT_STOP)
      chr.data <= {rx_in, chr.data[7:1]};
    if (sample && bit_cnt == BIT_STOP)
      chr.brk <= stop_bad;  // framing error flag
  end

endmodule

//--- logic/rx_merge.sv
/*
  Merges the character strobes of two receivers into one tagged stream.
  Each line has a one-deep hold slot; one character leaves per cycle.
  A held line b character goes before a new line a strobe.
*/

`timescale 1ns/1ps

module rx_merge (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   a_valid,
  input  uart_pkg::rx_char_t     a_chr,
  input  logic                   b_valid,
  input  uart_pkg::rx_char_t     b_chr,
  output logic                   out_valid,  // one cycle per character
  output uart_pkg::tagged_char_t out_char    // stable between strobes
);

  import uart_pkg::*;

  // source of the character leaving this cycle
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_A_HOLD,
    SEL_B_HOLD,
    SEL_A_IN,
    SEL_B_IN
  } sel_t;

  sel_t         sel;
  tagged_char_t emit_char;  // next out_char
  rx_char_t     a_hold;     // waiting line a character
  rx_char_t     b_hold;     // waiting line b character
  logic         a_full;
  logic         b_full;
  logic         a_load;     // park the new a strobe
  logic         b_load;     // park the new b strobe
  logic         a_full_next;
  logic         b_full_next;

  // oldest first, line a wins a tie between new strobes
  always_comb
  begin
    if (b_full)
      sel = SEL_B_HOLD;
    else if (a_full)
      sel = SEL_A_HOLD;
    else if (a_valid)
      sel = SEL_A_IN;
    else if (b_valid)
      sel = SEL_B_IN;
    else
      sel = SEL_NONE;
  end

  always_comb
  begin
    emit_char = out_char;  // hold value when idle
    case (sel)
      SEL_A_HOLD:
      begin
        emit_char.line = LINE_A;
        emit_char.chr  = a_hold;
      end
      SEL_B_HOLD:
      begin
        emit_char.line = LINE_B;
        emit_char.chr  = b_hold;
      end
      SEL_A_IN:
      begin
        emit_char.line = LINE_A;
        emit_char.chr  = a_chr;
      end
      SEL_B_IN:
      begin
        emit_char.line = LINE_B;
        emit_char.chr  = b_chr;
      end
      default:
        emit_char = out_char;
    endcase
  end

  // a strobe not sent straight out goes to its slot
  assign a_load      = a_valid && (sel != SEL_A_IN);
  assign b_load      = b_valid && (sel != SEL_B_IN);
  assign a_full_next = a_load || (a_full && sel != SEL_A_HOLD);
  assign b_full_next = b_load || (b_full && sel != SEL_B_HOLD);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      a_full    <= 1'b0;
      b_full    <= 1'b0;
      out_valid <= 1'b0;
      out_char  <= '0;
    end
    else
    begin
      a_full    <= a_full_next;
      b_full    <= b_full_next;
      out_valid <= (sel != SEL_NONE);
      out_char  <= emit_char;
    end
  end

  // slot payload, valid only while the flag is set
  always_ff @(posedge clk)
  begin
    if (a_load)
      a_hold <= a_chr;
    if (b_load)
      b_hold <= b_chr;
  end

endmodule

//--- logic/dual_rx_top.sv
/*
  Two-line serial receive concentrator.
  Lines rx_a and rx_b each feed a receiver; the merger tags and serializes
  their characters onto out_valid and out_char, with no back-pressure.
*/

`timescale 1ns/1ps

module dual_rx_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   rx_a,       // async line a
  input  logic                   rx_b,       // async line b
  output logic                   out_valid,  // one cycle per character
  output uart_pkg::tagged_char_t out_char
);

  import uart_pkg::*;

  logic     a_valid;  // line a frame done
  rx_char_t a_chr;
  logic     b_valid;  // line b frame done
  rx_char_t b_chr;

  serial_rx rx_a_i (
    .clk    (clk),
    .arst_n (arst_n),
    .rx     (rx_a),
    .valid  (a_valid),
    .chr    (a_chr)
  );

  serial_rx rx_b_i (
    .clk    (clk),
    .arst_n (arst_n),
    .rx     (rx_b),
    .valid  (b_valid),
    .chr    (b_chr)
  );

  // one or two cycles from a receiver strobe to out_valid
  rx_merge merge_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .a_valid   (a_valid),
    .a_chr     (a_chr),
    .b_valid   (b_valid),
    .b_chr     (b_chr),
    .out_valid (out_valid),
    .out_char  (out_char)
  );

endmodule

//--- tests/dual_rx_asserts.sv
/*
  Concurrent checks on the concentrator top level.
  Bound into dual_rx_top so that the receiver strobes are visible.
*/

`timescale 1ns/1ps

module dual_rx_asserts (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   a_valid,    // line a receiver strobe
  input logic                   b_valid,    // line b receiver strobe
  input logic                   out_valid,
  input uart_pkg::tagged_char_t out_char
);

  import uart_pkg::*;

  // back to back outputs only after a double arrival
  property burst_after_pair;
    @(posedge clk) disable iff (!arst_n)
      out_valid && $past(out_valid) |-> $past(a_valid, 2) || $past(b_valid, 2);
  endproperty

  // async reset keeps the output quiet
  property quiet_in_reset;
    @(posedge clk) !arst_n |-> !out_valid;
  endproperty

  // each output traces back to its own line
  property tag_has_source;
    @(posedge clk) disable iff (!arst_n)
      out_valid |-> (out_char.line == LINE_A) ? ($past(a_valid) || $past(a_valid, 2))
                                              : ($past(b_valid) || $past(b_valid, 2));
  endproperty

  burst_chk: assert property (burst_after_pair)
    else $error("out_valid high twice in a row without two strobes before it");
  reset_chk: assert property (quiet_in_reset)
    else $error("out_valid high while reset is asserted");
  tag_chk: assert property (tag_has_source)
    else $error("out_char tag has no matching receiver strobe one or two cycles earlier");

endmodule

//--- tests/dual_rx_tb.sv
/*
  Directed testbench for the two-line receive concentrator.
  Serializes frames onto rx_a and rx_b, collects every out_valid strobe in a queue
  and checks tag, data and break flag against the expected characters.
*/

`timescale 1ns/1ps

`include "uart_settings.svh"

module dual_rx_tb;

  import uart_pkg::*;

  localparam int BIT_CLKS  = `UART_CLK_FREQ / `UART_BIT_FREQ;  // clocks per bit
  localparam int CLK_HALF  = 20;  // 40 ns clock
  localparam int DRIVE_DLY = 2;   // input skew after posedge
  localparam int N_FRAMES  = 8 + 2 + 4 + 4 + 16;  // frames and glitches sent
  // 10 bits per frame plus 4 bits of gaps and checks each
  localparam int TIMEOUT_CYCLES = N_FRAMES * (10 + 4) * BIT_CLKS;

  logic         clk;
  logic         arst_n;
  logic         rx_a;
  logic         rx_b;
  logic         out_valid;
  tagged_char_t out_char;

  tagged_char_t rx_q[$];     // collected outputs
  logic [15:0]  lfsr_state;
  int           cycle_cnt;
  int           mismatch_cnt;
  int           missing_cnt;
  int           extra_cnt;

  dual_rx_top dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .rx_a      (rx_a),
    .rx_b      (rx_b),
    .out_valid (out_valid),
    .out_char  (out_char)
  );

  bind dual_rx_top dual_rx_asserts asserts_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .a_valid   (a_valid),
    .b_valid   (b_valid),
    .out_valid (out_valid),
    .out_char  (out_char)
  );

  initial
  begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // sample away from the active edge
  always @(negedge clk)
  begin
    if (arst_n && out_valid)
      rx_q.push_back(out_char);
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: tests still running after %0d cycles", cycle_cnt);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // 16 bit galois lfsr, one step per bit
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    else
      return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val[i]     = lfsr_state[0];  // lsb is the bit taken
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic tagged_char_t make_char(input line_t ln, input logic [7:0] data,
                                             input logic brk);
    tagged_char_t c;
    c.line     = ln;
    c.chr.data = data;
    c.chr.brk  = brk;
    return c;
  endfunction

  task automatic set_line(input line_t ln, input logic level);
    if (ln == LINE_A)
      rx_a = level;
    else
      rx_b = level;
  endtask

  task automatic wait_bit();
    repeat (BIT_CLKS) @(posedge clk);
    #DRIVE_DLY;
  endtask

  // start, 8 data lsb first, stop, then two idle bits
  task automatic send_frame(input line_t ln, input logic [7:0] data, input logic stop_level);
    @(posedge clk);
    #DRIVE_DLY;
    set_line(ln, `UART_START_BIT);
    wait_bit();
    for (int i = 0; i < 8; i++)
    begin
      set_line(ln, data[i]);
      wait_bit();
    end
    set_line(ln, stop_level);
    wait_bit();
    set_line(ln, `UART_IDLE_BIT);  // also ends a break
    wait_bit();
    wait_bit();
  endtask

  task automatic check_char(input tagged_char_t exp);
    int           waited;
    tagged_char_t got;
    waited = 0;
    while (rx_q.size() == 0 && waited < 3 * BIT_CLKS)
    begin
      @(posedge clk);  // queue only grows on negedge
      waited++;
    end
    if (rx_q.size() == 0)
    begin
      $display("no character arrived from line %0d within three bit periods", exp.line);
      missing_cnt++;
    end
    else
    begin
      got = rx_q.pop_front();
      if (got !== exp)
      begin
        $display("MISMATCH out_char: expected 0x%h got 0x%h", exp, got);
        mismatch_cnt++;
      end
    end
  endtask

  task automatic check_none();
    tagged_char_t got;
    repeat (2 * BIT_CLKS) @(posedge clk);  // long enough for a late strobe
    while (rx_q.size() != 0)
    begin
      got = rx_q.pop_front();
      $display("unexpected character from line %0d with data 0x%h", got.line, got.chr.data);
      extra_cnt++;
    end
  endtask

  task automatic check_reset_state(input logic exp_valid, input tagged_char_t exp_char);
    if (out_valid !== exp_valid)
    begin
      $display("MISMATCH out_valid: expected 0x%h got 0x%h", exp_valid, out_valid);
      mismatch_cnt++;
    end
    if (out_char !== exp_char)
    begin
      $display("MISMATCH out_char: expected 0x%h got 0x%h", exp_char, out_char);
      mismatch_cnt++;
    end
  endtask

  // oldest first; tag decides the order unless both started together
  task automatic check_pair(input tagged_char_t exp_a, input tagged_char_t exp_b,
                            input logic same_start);
    int waited;
    waited = 0;
    while (rx_q.size() < 2 && waited < 3 * BIT_CLKS)
    begin
      @(posedge clk);
      waited++;
    end
    if (!same_start && rx_q.size() != 0 && rx_q[0].line == LINE_B)
    begin
      check_char(exp_b);
      check_char(exp_a);
    end
    else
    begin
      check_char(exp_a);
      check_char(exp_b);
    end
  endtask

  task automatic test_single_line();
    logic [7:0] vals [4];
    line_t      ln;
    vals = '{8'h00, 8'hFF, 8'hA5, 8'h5A};
    for (int l = 0; l < 2; l++)
    begin
      ln = line_t'(l);
      foreach (vals[i])
      begin
        send_frame(ln, vals[i], `UART_STOP_BIT);
        check_char(make_char(ln, vals[i], 1'b0));
      end
    end
  endtask

  task automatic test_simultaneous();
    fork
      send_frame(LINE_A, 8'h12, `UART_STOP_BIT);
      send_frame(LINE_B, 8'h34, `UART_STOP_BIT);
    join
    check_char(make_char(LINE_A, 8'h12, 1'b0));  // a wins the tie
    check_char(make_char(LINE_B, 8'h34, 1'b0));
  endtask

  task automatic test_framing_error();
    line_t ln;
    for (int l = 0; l < 2; l++)
    begin
      ln = line_t'(l);
      send_frame(ln, 8'h3C, ~`UART_STOP_BIT);  // low stop bit
      check_char(make_char(ln, 8'h3C, 1'b1));
      send_frame(ln, 8'hC3, `UART_STOP_BIT);   // recovery frame
      check_char(make_char(ln, 8'hC3, 1'b0));
    end
  endtask

  task automatic test_false_start();
    line_t ln;
    for (int l = 0; l < 2; l++)
    begin
      ln = line_t'(l);
      @(posedge clk);
      #DRIVE_DLY;
      set_line(ln, `UART_START_BIT);
      repeat (BIT_CLKS / 4) @(posedge clk);  // well under half a bit
      #DRIVE_DLY;
      set_line(ln, `UART_IDLE_BIT);
      check_none();
      send_frame(ln, 8'h69, `UART_STOP_BIT);
      check_char(make_char(ln, 8'h69, 1'b0));
    end
  endtask

  task automatic test_random_traffic();
    logic [7:0] da;
    logic [7:0] db;
    logic [7:0] off;
    logic [7:0] lead;
    for (int k = 0; k < 8; k++)
    begin
      take_bits(8, da);
      take_bits(8, db);
      take_bits(3, off);   // 0..7 cycles, under half a bit
      take_bits(1, lead);  // which line starts late
      fork
        begin
          if (lead[0])
            repeat (off) @(posedge clk);
          send_frame(LINE_A, da, `UART_STOP_BIT);
        end
        begin
          if (!lead[0])
            repeat (off) @(posedge clk);
          send_frame(LINE_B, db, `UART_STOP_BIT);
        end
      join
      check_pair(make_char(LINE_A, da, 1'b0), make_char(LINE_B, db, 1'b0), off == 0);
    end
  endtask

  initial
  begin
    arst_n       = 1'b0;
    rx_a         = `UART_IDLE_BIT;
    rx_b         = `UART_IDLE_BIT;
    lfsr_state   = 16'd47;
    cycle_cnt    = 0;
    mismatch_cnt = 0;
    missing_cnt  = 0;
    extra_cnt    = 0;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    @(negedge clk);
    check_reset_state(1'b0, '0);
    test_single_line();
    test_simultaneous();
    test_framing_error();
    test_false_start();
    test_random_traffic();
    check_none();  // nothing left over
    $display("errors: %0d mismatched, %0d missing, %0d unexpected",
             mismatch_cnt, missing_cnt, extra_cnt);
    if (mismatch_cnt + missing_cnt + extra_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+common
common/uart_pkg.sv
serial_rx/serial_rx.sv
logic/rx_merge.sv
logic/dual_rx_top.sv
tests/dual_rx_asserts.sv
tests/dual_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the concentrator testbench with Verilator and run it.
# Exit status is 0 only when the simulation prints the pass message.

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module dual_rx_tb \
  -f verilog.f

sim_status=0
sim_out=$(./obj_dir/Vdual_rx_tb 2>&1) || sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -eq 0 ] && printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
